/* Bender.yml */
package:
  name: rename_unit

sources:
  - rename_pkg.sv
  - map_lookup_if.sv
  - map_table.sv
  - free_list.sv
  - rename_ctrl.sv
  - rename_unit.sv
  - target: simulation
    files:
      - tb_rename_unit.sv

/* free_list.sv */
// Free physical register queue
`timescale 1ns/10ps

module free_list (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pop,
    input  logic                  push,
    input  rename_pkg::phys_idx_t push_pr,
    input  logic                  retire,
    input  logic                  restore,
    output rename_pkg::phys_idx_t head_pr,
    output logic                  empty
);

    localparam int IDX_W = $clog2(rename_pkg::FREE_DEPTH);

    // One wrap bit above the slot index tells full from empty
    typedef logic [IDX_W:0] ptr_t;

    rename_pkg::phys_idx_t slots [rename_pkg::FREE_DEPTH];

    // Slots from ret_head up to spec_head hold registers in flight,
    // slots from spec_head up to tail are free
    ptr_t spec_head;
    ptr_t ret_head;
    ptr_t tail;

    assign head_pr = slots[spec_head[IDX_W-1:0]];

    // Free count is tail minus spec_head, so it follows any head move
    assign empty = (spec_head == tail);

    always_ff @(posedge clk) begin
        if (reset) begin
            // Physical registers above the architectural ones start free
            for (int i = 0; i < rename_pkg::FREE_DEPTH; i++) begin
                slots[i] <= rename_pkg::phys_idx_t'(rename_pkg::NUM_ARCH_REGS + i);
            end
            spec_head <= '0;
            ret_head  <= '0;
            tail      <= ptr_t'(rename_pkg::FREE_DEPTH);
        end else if (restore) begin
            // Registers popped since the last retire are handed out again
            spec_head <= ret_head;
        end else begin
            if (pop) begin
                spec_head <= spec_head + 1'b1;
            end

            if (retire) begin
                ret_head <= ret_head + 1'b1;
            end

            // Goes into the slot the retire just released
            if (push) begin
                slots[tail[IDX_W-1:0]] <= push_pr;
                tail                   <= tail + 1'b1;
            end
        end
    end

endmodule

/* map_lookup_if.sv */
// Rename lookup bundle
`timescale 1ns/10ps

interface map_lookup_if;

    // Source and dest indices from the controller
    rename_pkg::arch_idx_t src1_idx;
    rename_pkg::arch_idx_t src2_idx;
    rename_pkg::arch_idx_t dest_idx;

    // One-cycle pulse, dest entry takes new_pr at the edge
    logic                  set_dest;
    rename_pkg::phys_idx_t new_pr;

    // Combinational results from the map table
    rename_pkg::preg_t     src1_pr;
    rename_pkg::preg_t     src2_pr;
    // Value before this cycle's dest write
    rename_pkg::preg_t     old_dest_pr;

    modport ctrl (
        output src1_idx,
        output src2_idx,
        output dest_idx,
        output set_dest,
        output new_pr,
        input  src1_pr,
        input  src2_pr,
        input  old_dest_pr
    );

    modport tbl (
        input  src1_idx,
        input  src2_idx,
        input  dest_idx,
        input  set_dest,
        input  new_pr,
        output src1_pr,
        output src2_pr,
        output old_dest_pr
    );

endinterface

/* map_table.sv */
// Speculative and retired rename maps
`timescale 1ns/10ps

module map_table (
    input  logic                  clk,
    input  logic                  reset,
    map_lookup_if.tbl             lookup,
    input  logic                  rt_valid,
    input  rename_pkg::arch_idx_t rt_arch,
    input  rename_pkg::phys_idx_t rt_pr,
    input  logic                  cdb_valid,
    input  rename_pkg::phys_idx_t cdb_pr,
    input  logic                  restore,
    input  rename_pkg::arch_idx_t query_arch,
    output rename_pkg::phys_idx_t freed_pr,
    output rename_pkg::phys_idx_t query_pr
);

    localparam int LAST_ARCH = rename_pkg::NUM_ARCH_REGS - 1;

    // Arch 0 has no storage, it reads as phys 0, always ready
    localparam rename_pkg::preg_t ZERO_ENTRY = '{reg_num: '0, ready: 1'b1};

    rename_pkg::preg_t spec_map [1:LAST_ARCH];
    rename_pkg::preg_t ret_map  [1:LAST_ARCH];

    // Speculative read, a broadcast in this cycle already counts as ready
    function automatic rename_pkg::preg_t read_spec(input rename_pkg::arch_idx_t idx);
        rename_pkg::preg_t entry;
        if (idx == rename_pkg::ZERO_REG) begin
            entry = ZERO_ENTRY;
        end else begin
            entry = spec_map[idx];
            if (cdb_valid && (cdb_pr == entry.reg_num)) begin
                entry.ready = 1'b1;
            end
        end
        return entry;
    endfunction

    // Rename lookups
    always_comb begin
        lookup.src1_pr     = read_spec(lookup.src1_idx);
        lookup.src2_pr     = read_spec(lookup.src2_idx);
        lookup.old_dest_pr = read_spec(lookup.dest_idx);
    end

    // Retired map reads, the register replaced by a retire and the query port
    always_comb begin
        if (rt_arch == rename_pkg::ZERO_REG) begin
            freed_pr = ZERO_ENTRY.reg_num;
        end else begin
            freed_pr = ret_map[rt_arch].reg_num;
        end

        if (query_arch == rename_pkg::ZERO_REG) begin
            query_pr = ZERO_ENTRY.reg_num;
        end else begin
            query_pr = ret_map[query_arch].reg_num;
        end
    end

    // Map updates
    always_ff @(posedge clk) begin
        if (reset) begin
            // Identity mapping, everything ready
            for (int i = 1; i <= LAST_ARCH; i++) begin
                spec_map[i] <= '{reg_num: rename_pkg::phys_idx_t'(i), ready: 1'b1};
                ret_map[i]  <= '{reg_num: rename_pkg::phys_idx_t'(i), ready: 1'b1};
            end
        end else if (restore) begin
            // Roll back, retired entries are all ready so a CDB here is not lost
            for (int i = 1; i <= LAST_ARCH; i++) begin
                spec_map[i] <= ret_map[i];
            end
        end else begin
            // Mark every speculative entry holding the broadcast register
            if (cdb_valid) begin
                for (int i = 1; i <= LAST_ARCH; i++) begin
                    if (spec_map[i].reg_num == cdb_pr) begin
                        spec_map[i].ready <= 1'b1;
                    end
                end
            end

            // Dest write comes last and wins over the broadcast above,
            // so the new register stays pending even if the old one was marked
            if (lookup.set_dest && (lookup.dest_idx != rename_pkg::ZERO_REG)) begin
                spec_map[lookup.dest_idx] <= '{reg_num: lookup.new_pr, ready: 1'b0};
            end

            // Commit, a retired value has always been produced
            if (rt_valid && (rt_arch != rename_pkg::ZERO_REG)) begin
                ret_map[rt_arch] <= '{reg_num: rt_pr, ready: 1'b1};
            end
        end
    end

endmodule

/* rename_ctrl.sv */
// Rename handshake controller
`timescale 1ns/10ps

module rename_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    map_lookup_if.ctrl            lookup,
    input  logic                  rn_req,
    input  rename_pkg::arch_idx_t rn_src1,
    input  rename_pkg::arch_idx_t rn_src2,
    input  rename_pkg::arch_idx_t rn_dest,
    input  logic                  free_empty,
    input  rename_pkg::phys_idx_t free_pr,
    input  logic                  restore,
    output logic                  rn_ack,
    output rename_pkg::preg_t     rn_src1_pr,
    output rename_pkg::preg_t     rn_src2_pr,
    output rename_pkg::phys_idx_t rn_new_pr,
    output rename_pkg::phys_idx_t rn_old_pr,
    output logic                  pop
);

    rename_pkg::rename_state_t state;
    rename_pkg::rename_state_t state_next;

    // The rename edge happens this cycle
    logic go;
    // A dest register is taken from the free list
    logic alloc;

    // Client holds its fields stable for the whole handshake
    assign lookup.src1_idx = rn_src1;
    assign lookup.src2_idx = rn_src2;
    assign lookup.dest_idx = rn_dest;

    // Stall on an empty free list or a rollback in progress
    assign go    = (state == rename_pkg::s_rename) && !free_empty && !restore;
    assign alloc = go && (rn_dest != rename_pkg::ZERO_REG);

    assign lookup.set_dest = alloc;
    assign lookup.new_pr   = free_pr;
    assign pop             = alloc;

    assign rn_ack = (state == rename_pkg::s_release);

    always_comb begin
        state_next = state;
        case (state)
            rename_pkg::s_idle: begin
                if (rn_req) begin
                    state_next = rename_pkg::s_rename;
                end
            end
            rename_pkg::s_rename: begin
                if (go) begin
                    state_next = rename_pkg::s_ack;
                end
            end
            rename_pkg::s_ack: begin
                state_next = rename_pkg::s_release;
            end
            rename_pkg::s_release: begin
                if (!rn_req) begin
                    state_next = rename_pkg::s_idle;
                end
            end
            default: state_next = rename_pkg::s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rename_pkg::s_idle;
        end else begin
            state <= state_next;
        end
    end

    // Results captured at the rename edge, held until the next request
    always_ff @(posedge clk) begin
        if (go) begin
            rn_src1_pr <= lookup.src1_pr;
            rn_src2_pr <= lookup.src2_pr;
            rn_new_pr  <= alloc ? free_pr : '0;
            rn_old_pr  <= lookup.old_dest_pr.reg_num;
        end
    end

endmodule

/* rename_pkg.sv */
// Register rename types
package rename_pkg;

    // Register file sizes
    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;

    // Physical registers not held by the retired map, minus nothing:
    // arch 0 pins phys 0, so 63 registers share 31 map entries and 32 slots
    localparam int FREE_DEPTH = NUM_PHYS_REGS - NUM_ARCH_REGS;

    // Architectural register index
    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_idx_t;

    // Physical register index
    typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phys_idx_t;

    // Map entry, physical register plus its ready bit
    typedef struct packed {
        phys_idx_t reg_num;
        logic      ready;
    } preg_t;

    // Hardwired zero register
    localparam arch_idx_t ZERO_REG = '0;

    // Rename handshake states
    //   s_idle     waiting for a request
    //   s_rename   lookup, dest write and pop, stalls on empty or restore
    //   s_ack      results registered, ack about to rise
    //   s_release  ack high until the client drops its request
    typedef enum logic [1:0] {
        s_idle,
        s_rename,
        s_ack,
        s_release
    } rename_state_t;

endpackage

/* rename_unit.sv */
// Register rename unit
`timescale 1ns/10ps

module rename_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rn_req,
    input  rename_pkg::arch_idx_t rn_src1,
    input  rename_pkg::arch_idx_t rn_src2,
    input  rename_pkg::arch_idx_t rn_dest,
    input  logic                  rt_valid,
    input  rename_pkg::arch_idx_t rt_arch,
    input  rename_pkg::phys_idx_t rt_pr,
    input  logic                  cdb_valid,
    input  rename_pkg::phys_idx_t cdb_pr,
    input  logic                  restore,
    input  rename_pkg::arch_idx_t query_arch,
    output logic                  rn_ack,
    output rename_pkg::preg_t     rn_src1_pr,
    output rename_pkg::preg_t     rn_src2_pr,
    output rename_pkg::phys_idx_t rn_new_pr,
    output rename_pkg::phys_idx_t rn_old_pr,
    output rename_pkg::phys_idx_t query_pr,
    output logic                  free_empty
);

    rename_pkg::phys_idx_t freed_pr;
    rename_pkg::phys_idx_t free_pr;
    logic                  pop;
    // Retire of arch 0 has no register to give back
    logic                  rt_free;

    assign rt_free = rt_valid && (rt_arch != rename_pkg::ZERO_REG);

    map_lookup_if lookup_bus ();

    map_table map_table_i (
        .clk        (clk),
        .reset      (reset),
        .lookup     (lookup_bus.tbl),
        .rt_valid   (rt_valid),
        .rt_arch    (rt_arch),
        .rt_pr      (rt_pr),
        .cdb_valid  (cdb_valid),
        .cdb_pr     (cdb_pr),
        .restore    (restore),
        .query_arch (query_arch),
        .freed_pr   (freed_pr),
        .query_pr   (query_pr)
    );

    free_list free_list_i (
        .clk     (clk),
        .reset   (reset),
        .pop     (pop),
        .push    (rt_free),
        .push_pr (freed_pr),
        .retire  (rt_free),
        .restore (restore),
        .head_pr (free_pr),
        .empty   (free_empty)
    );

    rename_ctrl rename_ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .lookup     (lookup_bus.ctrl),
        .rn_req     (rn_req),
        .rn_src1    (rn_src1),
        .rn_src2    (rn_src2),
        .rn_dest    (rn_dest),
        .free_empty (free_empty),
        .free_pr    (free_pr),
        .restore    (restore),
        .rn_ack     (rn_ack),
        .rn_src1_pr (rn_src1_pr),
        .rn_src2_pr (rn_src2_pr),
        .rn_new_pr  (rn_new_pr),
        .rn_old_pr  (rn_old_pr),
        .pop        (pop)
    );

endmodule

/* sources.f */
rename_pkg.sv
map_lookup_if.sv
map_table.sv
free_list.sv
rename_ctrl.sv
rename_unit.sv
tb_rename_unit.sv

/* tb_rename_unit.sv */
// Rename unit testbench
`timescale 1ns/10ps

module tb_rename_unit;

    localparam int RAND_COUNT = 200;
    localparam int HS_LIMIT   = 10;
    localparam int LAST_ARCH  = rename_pkg::NUM_ARCH_REGS - 1;

    typedef enum {op_rename, op_retire, op_cdb, op_restore, op_query, op_drain} op_kind_t;

    // a and b hold the sources or the query index and c the dest
    // p is the register broadcast on the CDB or -1 for none
    typedef struct {
        op_kind_t kind;
        int       a;
        int       b;
        int       c;
        int       p;
        string    name;
    } op_t;

    logic                  clk;
    logic                  reset;
    logic                  rn_req;
    rename_pkg::arch_idx_t rn_src1;
    rename_pkg::arch_idx_t rn_src2;
    rename_pkg::arch_idx_t rn_dest;
    logic                  rt_valid;
    rename_pkg::arch_idx_t rt_arch;
    rename_pkg::phys_idx_t rt_pr;
    logic                  cdb_valid;
    rename_pkg::phys_idx_t cdb_pr;
    logic                  restore;
    rename_pkg::arch_idx_t query_arch;
    logic                  rn_ack;
    rename_pkg::preg_t     rn_src1_pr;
    rename_pkg::preg_t     rn_src2_pr;
    rename_pkg::phys_idx_t rn_new_pr;
    rename_pkg::phys_idx_t rn_old_pr;
    rename_pkg::phys_idx_t query_pr;
    logic                  free_empty;

    // Reference model that also plays the reorder buffer
    int  spec_pr  [rename_pkg::NUM_ARCH_REGS];
    bit  spec_rdy [rename_pkg::NUM_ARCH_REGS];
    int  ret_pr   [rename_pkg::NUM_ARCH_REGS];
    int  free_q   [$];
    int  rob_arch [$];
    int  rob_pr   [$];

    op_t ops [$];
    bit  ops_ready = 1'b0;
    int  test_errs;
    int  test_count;
    int  fail_count;
    int  err_count;

    rename_unit rename_unit_i (
        .clk        (clk),
        .reset      (reset),
        .rn_req     (rn_req),
        .rn_src1    (rn_src1),
        .rn_src2    (rn_src2),
        .rn_dest    (rn_dest),
        .rt_valid   (rt_valid),
        .rt_arch    (rt_arch),
        .rt_pr      (rt_pr),
        .cdb_valid  (cdb_valid),
        .cdb_pr     (cdb_pr),
        .restore    (restore),
        .query_arch (query_arch),
        .rn_ack     (rn_ack),
        .rn_src1_pr (rn_src1_pr),
        .rn_src2_pr (rn_src2_pr),
        .rn_new_pr  (rn_new_pr),
        .rn_old_pr  (rn_old_pr),
        .query_pr   (query_pr),
        .free_empty (free_empty)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic op_t make_op(op_kind_t kind, int a, int b, int c, int p, string name);
        op_t op;
        op.kind = kind;
        op.a    = a;
        op.b    = b;
        op.c    = c;
        op.p    = p;
        op.name = name;
        return op;
    endfunction

    function automatic void add_op(op_kind_t kind, int a, int b, int c, int p, string name);
        ops.push_back(make_op(kind, a, b, c, p, name));
    endfunction

    function automatic void report_mismatch(string test, string field, int exp, int act);
        $display("Error: %s %s expected %0d actual %0d", test, field, exp, act);
        test_errs++;
    endfunction

    function automatic void report_failure(string test, string what);
        $display("%s: %s", test, what);
        test_errs++;
    endfunction

    function automatic void model_reset();
        for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
            spec_pr[i]  = i;
            spec_rdy[i] = 1'b1;
            ret_pr[i]   = i;
        end
        free_q.delete();
        rob_arch.delete();
        rob_pr.delete();
        for (int i = rename_pkg::NUM_ARCH_REGS; i < rename_pkg::NUM_PHYS_REGS; i++) begin
            free_q.push_back(i);
        end
    endfunction

    // Broadcast readies every speculative entry holding that register
    function automatic void model_cdb(int p);
        for (int i = 1; i <= LAST_ARCH; i++) begin
            if (spec_pr[i] == p) begin
                spec_rdy[i] = 1'b1;
            end
        end
    endfunction

    function automatic rename_pkg::preg_t expect_src(int a);
        rename_pkg::preg_t e;
        e.reg_num = rename_pkg::phys_idx_t'(spec_pr[a]);
        e.ready   = spec_rdy[a];
        return e;
    endfunction

    // All driving tasks start and end on a falling edge
    task automatic retire_oldest(string test);
        int arch;
        int pr;
        if (rob_arch.size() == 0) begin
            report_failure(test, "no renamed instruction is left to retire");
            return;
        end
        arch = rob_arch.pop_front();
        pr   = rob_pr.pop_front();
        free_q.push_back(ret_pr[arch]);
        ret_pr[arch] = pr;
        rt_valid   = 1'b1;
        rt_arch    = arch;
        rt_pr      = pr;
        query_arch = arch;
        @(negedge clk);
        rt_valid = 1'b0;
        if (query_pr !== pr) report_mismatch(test, "query_pr", pr, query_pr);
    endtask

    task automatic rename_op(string test, int s1, int s2, int d, int p);
        rename_pkg::preg_t exp_s1;
        rename_pkg::preg_t exp_s2;
        int                exp_new;
        int                exp_old;
        int                waited;
        bit                stalled;
        rn_src1 = s1;
        rn_src2 = s2;
        rn_dest = d;
        rn_req  = 1'b1;
        stalled = (free_q.size() == 0);
        // With the free list empty the request waits for a retire
        if (stalled) begin
            repeat (4) begin
                @(negedge clk);
                if (rn_ack !== 1'b0) report_failure(test, "rn_ack rose with an empty free list");
                if (free_empty !== 1'b1) begin
                    report_failure(test, "free_empty is low with no free register");
                end
            end
            retire_oldest(test);
        end
        if (p >= 0) model_cdb(p);
        exp_s1 = expect_src(s1);
        exp_s2 = expect_src(s2);
        exp_new = 0;
        exp_old = 0;
        if (d != 0) begin
            exp_new = free_q.pop_front();
            exp_old = spec_pr[d];
            spec_pr[d]  = exp_new;
            spec_rdy[d] = 1'b0;
            rob_arch.push_back(d);
            rob_pr.push_back(exp_new);
        end
        waited = 0;
        while (rn_ack !== 1'b1 && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
            // CDB pulse lands exactly on the rename edge
            if (p >= 0 && waited == 1) begin
                cdb_valid = 1'b1;
                cdb_pr    = p;
            end
            if (waited == 2) cdb_valid = 1'b0;
        end
        cdb_valid = 1'b0;
        if (rn_ack !== 1'b1) begin
            report_failure(test, "rn_ack did not rise, the handshake never completed");
        end else begin
            if (!stalled && waited != 3) begin
                report_failure(test, "rn_ack did not rise two cycles after rn_req was sampled");
            end
            if (rn_src1_pr !== exp_s1) report_mismatch(test, "rn_src1_pr", exp_s1, rn_src1_pr);
            if (rn_src2_pr !== exp_s2) report_mismatch(test, "rn_src2_pr", exp_s2, rn_src2_pr);
            if (rn_new_pr !== exp_new) report_mismatch(test, "rn_new_pr", exp_new, rn_new_pr);
            if (rn_old_pr !== exp_old) report_mismatch(test, "rn_old_pr", exp_old, rn_old_pr);
        end
        rn_req = 1'b0;
        waited = 0;
        while (rn_ack !== 1'b0 && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (rn_ack !== 1'b0) report_failure(test, "rn_ack stayed high after rn_req dropped");
    endtask

    task automatic restore_op(string test);
        for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
            spec_pr[i]  = ret_pr[i];
            spec_rdy[i] = 1'b1;
        end
        // In-flight registers go back in front of the free ones
        for (int k = rob_pr.size() - 1; k >= 0; k--) begin
            free_q.push_front(rob_pr[k]);
        end
        rob_arch.delete();
        rob_pr.delete();
        restore = 1'b1;
        @(negedge clk);
        restore = 1'b0;
        if (free_empty !== (free_q.size() == 0)) begin
            report_mismatch(test, "free_empty", free_q.size() == 0, free_empty);
        end
    endtask

    task automatic query_op(string test, int a);
        query_arch = a;
        @(negedge clk);
        if (query_pr !== ret_pr[a]) report_mismatch(test, "query_pr", ret_pr[a], query_pr);
    endtask

    task automatic run_op(op_t op);
        test_errs = 0;
        case (op.kind)
            op_rename: rename_op(op.name, op.a, op.b, op.c, op.p);
            op_retire: retire_oldest(op.name);
            op_restore: restore_op(op.name);
            op_cdb: begin
                model_cdb(op.p);
                cdb_valid = 1'b1;
                cdb_pr    = op.p;
                @(negedge clk);
                cdb_valid = 1'b0;
            end
            op_query: begin
                if (op.a < 0) begin
                    for (int a = 0; a <= LAST_ARCH; a++) query_op(op.name, a);
                end else begin
                    query_op(op.name, op.a);
                end
            end
            op_drain: begin
                for (int d = 1; free_q.size() > 0; d = (d % LAST_ARCH) + 1) begin
                    rename_op(op.name, d, 0, d, -1);
                end
                if (free_empty !== 1'b1) begin
                    report_failure(op.name, "free_empty stayed low when drained");
                end
            end
        endcase
        test_count++;
        if (test_errs > 0) begin
            fail_count++;
            err_count += test_errs;
            $display("%s: %0d mismatches", op.name, test_errs);
        end else begin
            $display("%s: ok", op.name);
        end
    endtask

    // Watchdog allows 20 cycles per operation
    initial begin
        wait (ops_ready);
        repeat ((ops.size() + RAND_COUNT) * 20) @(posedge clk);
        $display("Watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int    seed_val;
        int    r;
        int    p;
        string name;
        seed_val   = $urandom(32'h2b8e_bd64);
        reset      = 1'b1;
        rn_req     = 1'b0;
        rn_src1    = '0;
        rn_src2    = '0;
        rn_dest    = '0;
        rt_valid   = 1'b0;
        rt_arch    = '0;
        rt_pr      = '0;
        cdb_valid  = 1'b0;
        cdb_pr     = '0;
        restore    = 1'b0;
        query_arch = '0;
        test_count = 0;
        fail_count = 0;
        err_count  = 0;

        add_op(op_query, -1, 0, 0, -1, "reset_query_all");
        add_op(op_rename, 1, 2, 0, -1, "reset_sources");
        add_op(op_rename, 0, 31, 3, -1, "alloc_first");
        add_op(op_rename, 3, 0, 4, -1, "alloc_second");
        add_op(op_rename, 3, 4, 0, -1, "dest_zero");
        add_op(op_cdb, 0, 0, 0, 32, "cdb_mark");
        add_op(op_rename, 3, 4, 5, -1, "cdb_later_lookup");
        add_op(op_rename, 4, 5, 4, 33, "cdb_forward");
        add_op(op_rename, 4, 0, 0, -1, "cdb_not_new");
        add_op(op_retire, 0, 0, 0, -1, "retire_r3");
        add_op(op_query, 3, 0, 0, -1, "query_r3");
        add_op(op_retire, 0, 0, 0, -1, "retire_r4");
        add_op(op_retire, 0, 0, 0, -1, "retire_r5");
        add_op(op_restore, 0, 0, 0, -1, "restore_spec");
        add_op(op_rename, 4, 5, 0, -1, "restore_sources");
        add_op(op_rename, 4, 0, 6, -1, "restore_reuse");
        add_op(op_retire, 0, 0, 0, -1, "retire_r6");
        add_op(op_drain, 0, 0, 0, -1, "drain_free_list");
        add_op(op_rename, 1, 2, 7, -1, "stall_on_empty");
        add_op(op_retire, 0, 0, 0, -1, "retire_after_stall");
        add_op(op_rename, 0, 7, 8, -1, "fifo_refill");
        add_op(op_query, -1, 0, 0, -1, "query_after_retire");
        ops_ready = 1'b1;
        model_reset();

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (ops[i]) run_op(ops[i]);

        // Random renames and broadcasts with retires in rename order
        for (int n = 0; n < RAND_COUNT; n++) begin
            r    = $urandom_range(0, 7);
            p    = spec_pr[$urandom_range(1, LAST_ARCH)];
            name = $sformatf("rand_%0d", n);
            if ((r >= 6 && rob_arch.size() > 0) || free_q.size() == 0) begin
                run_op(make_op(op_retire, 0, 0, 0, -1, name));
            end else if (r >= 4) begin
                run_op(make_op(op_cdb, 0, 0, 0, p, name));
            end else begin
                run_op(make_op(op_rename, $urandom_range(0, LAST_ARCH),
                               $urandom_range(0, LAST_ARCH), $urandom_range(0, LAST_ARCH),
                               (r == 0) ? p : -1, name));
            end
        end
        run_op(make_op(op_restore, 0, 0, 0, -1, "final_restore"));
        // Every source reads back its retired mapping
        for (int a = 1; a <= LAST_ARCH; a += 2) begin
            run_op(make_op(op_rename, a, (a + 1) % rename_pkg::NUM_ARCH_REGS, 0, -1,
                           $sformatf("final_sources_%0d", a)));
        end
        run_op(make_op(op_query, -1, 0, 0, -1, "final_query_all"));

        $display("Tests run %0d, failed %0d, errors %0d", test_count, fail_count, err_count);
        if (fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
